// File: src/hbus_pkg.sv
package hbus_pkg;

    localparam int mem_bits = 21;      // 2M words of 32 bits
    localparam int latency = 6;        // initial latency in bus clocks
    localparam int latency2x = 1;

    // system cycles between the last CA byte and the first data byte
    localparam int nop_cycles = latency * 2 * (latency2x + 1) - 2;
    localparam int nop_bits = $clog2(nop_cycles);

    localparam int paddr_bits = 23;    // byte address, two bits below the word

    typedef struct packed {
        logic                is_read;
        logic [mem_bits-1:0] addr;     // word address
        logic [31:0]         wdata;
        logic [3:0]          mask;     // a set bit leaves that byte untouched
    } hb_req_t;

    typedef struct packed {
        logic       ck;
        logic       ncs;
        logic       rwds;
        logic       rwds_oe;
        logic [7:0] dq;
        logic       dq_oe;
    } hb_pads_t;

    // idle is the all-zero code and every other state owns a single bit
    typedef enum logic [7:0] {
        st_idle = 8'h00,
        st_ca0  = 8'h01,
        st_ca1  = 8'h02,
        st_ca2  = 8'h04,
        st_ca3  = 8'h08,
        st_ca4  = 8'h10,
        st_ca5  = 8'h20,
        st_wait = 8'h40,
        st_data = 8'h80
    } hb_state_t;

endpackage

// File: src/apb_port.sv
module apb_port (
    input  logic                            clk,
    input  logic                            nreset,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [hbus_pkg::paddr_bits-1:0] paddr,
    input  logic [31:0]                     pwdata,
    input  logic [3:0]                      pstrb,
    output logic [31:0]                     prdata,
    output logic                            pready,
    output logic                            pslverr,
    output logic                            req_valid,
    output hbus_pkg::hb_req_t               req,
    input  logic                            done,
    input  logic [31:0]                     rd_word
);
    import hbus_pkg::*;

    logic access;       // first access cycle of a transfer not yet answered
    logic misaligned;

    assign access     = psel && penable && !req_valid && !pready;
    assign misaligned = paddr[1:0] != 2'b00;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            req_valid <= 1'b0;
            pready    <= 1'b0;
            pslverr   <= 1'b0;
        end else begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            if (done) begin
                // the sequencer is back in idle, so the request goes away with pready
                req_valid <= 1'b0;
                pready    <= 1'b1;
            end else if (access) begin
                if (misaligned) begin
                    pready  <= 1'b1;    // answered at once, no bus transaction
                    pslverr <= 1'b1;
                end else begin
                    req_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access && !misaligned) begin
            req.is_read <= !pwrite;
            req.addr    <= paddr[paddr_bits-1:2];
            req.wdata   <= pwdata;
            req.mask    <= pwrite ? ~pstrb : 4'hf;  // a read masks every byte
        end
        if (done) begin
            prdata <= rd_word;
        end
    end

endmodule

// File: src/hbus_sequencer.sv
module hbus_sequencer (
    input  logic               clk,
    input  logic               nreset,
    input  logic               req_valid,
    input  logic               is_read,
    output logic               done,
    output logic [2:0]         ca_index,
    output logic [1:0]         byte_index,
    output logic               byte_take,
    input  logic [7:0]         ca_byte,
    input  logic [7:0]         wr_byte,
    input  logic               wr_mask,
    input  logic               hb_rwds_in,
    output hbus_pkg::hb_pads_t pads
);
    import hbus_pkg::*;

    hb_state_t           state;
    logic [nop_bits-1:0] nop_cnt;
    logic                ck;
    logic                in_ca;
    logic                in_data;
    logic                step;        // the current data byte completes this cycle

    assign in_ca   = state inside {st_ca0, st_ca1, st_ca2, st_ca3, st_ca4, st_ca5};
    assign in_data = state == st_data;

    // on a read the first byte waits for the device to raise RWDS,
    // the rest follow on consecutive cycles
    assign step      = in_data && (!is_read || hb_rwds_in || byte_index != 2'd0);
    assign byte_take = step && is_read;
    assign done      = step && byte_index == 2'd3;

    always_comb begin
        case (state)
            st_ca1:  ca_index = 3'd1;
            st_ca2:  ca_index = 3'd2;
            st_ca3:  ca_index = 3'd3;
            st_ca4:  ca_index = 3'd4;
            st_ca5:  ca_index = 3'd5;
            default: ca_index = 3'd0;
        endcase
    end

    // bus clock at half the system rate, its edges sit mid-cycle so each byte
    // on dq is centred on one edge
    always_ff @(negedge clk) begin
        if (!nreset || state == st_idle) begin
            ck <= 1'b0;
        end else begin
            ck <= ~ck;
        end
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state      <= st_idle;
            nop_cnt    <= '0;
            byte_index <= 2'd0;
        end else begin
            case (state)
                st_idle: begin
                    if (req_valid) begin
                        state <= st_ca0;
                    end
                end
                st_ca0: state <= st_ca1;
                st_ca1: state <= st_ca2;
                st_ca2: state <= st_ca3;
                st_ca3: state <= st_ca4;
                st_ca4: state <= st_ca5;
                st_ca5: begin
                    state   <= st_wait;
                    nop_cnt <= nop_bits'(nop_cycles - 1);
                end
                st_wait: begin
                    byte_index <= 2'd0;
                    if (nop_cnt == '0) begin
                        state <= st_data;
                    end else begin
                        nop_cnt <= nop_cnt - 1'b1;
                    end
                end
                st_data: begin
                    if (step) begin
                        byte_index <= byte_index + 2'd1;
                        if (byte_index == 2'd3) begin
                            state <= st_idle;   // chip select rises with this
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_comb begin
        pads.ck      = ck;
        pads.ncs     = state == st_idle;
        pads.dq      = in_data ? wr_byte : ca_byte;
        // the device owns dq and RWDS through the latency wait and read data
        pads.dq_oe   = in_ca || (in_data && !is_read);
        pads.rwds    = in_data && !is_read && wr_mask;
        pads.rwds_oe = in_data && !is_read;
    end

endmodule

// File: src/ca_shifter.sv
module ca_shifter (
    input  hbus_pkg::hb_req_t req,
    input  logic [2:0]        ca_index,
    output logic [7:0]        ca_byte
);
    import hbus_pkg::*;

    logic [31:0] half_addr;   // the device counts in 16-bit halfwords
    logic [47:0] ca_word;

    assign half_addr = {{(31 - mem_bits){1'b0}}, req.addr, 1'b0};

    // bit 47 read, 46 memory space, 45 linear burst,
    // 44:16 upper column and row, 15:3 reserved, 2:0 lower column
    assign ca_word = {
        req.is_read,
        1'b0,
        1'b1,
        half_addr[31:3],
        13'h0000,
        half_addr[2:0]
    };

    always_comb begin
        case (ca_index)
            3'd0:    ca_byte = ca_word[47:40];
            3'd1:    ca_byte = ca_word[39:32];
            3'd2:    ca_byte = ca_word[31:24];
            3'd3:    ca_byte = ca_word[23:16];
            3'd4:    ca_byte = ca_word[15:8];
            3'd5:    ca_byte = ca_word[7:0];
            default: ca_byte = 8'h00;
        endcase
    end

endmodule

// File: src/word_lanes.sv
module word_lanes (
    input  logic              clk,
    input  logic              nreset,
    input  hbus_pkg::hb_req_t req,
    input  logic [1:0]        byte_index,
    input  logic              byte_take,
    input  logic [7:0]        hb_dq_in,
    output logic [7:0]        wr_byte,
    output logic              wr_mask,
    output logic [31:0]       rd_word
);

    logic [3:0][7:0] lanes;

    // least significant byte goes out first
    assign wr_byte = req.wdata[8*byte_index +: 8];
    assign wr_mask = req.mask[byte_index];

    always_ff @(posedge clk) begin
        if (!nreset) begin
            lanes <= '0;
        end else if (byte_take) begin
            lanes[byte_index] <= hb_dq_in;
        end
    end

    // the lane being taken passes straight through so the word is whole
    // in the cycle its last byte arrives
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (byte_take && byte_index == 2'(i)) begin
                rd_word[8*i +: 8] = hb_dq_in;
            end else begin
                rd_word[8*i +: 8] = lanes[i];
            end
        end
    end

endmodule

// File: src/hyperram_bridge.sv
module hyperram_bridge (
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [hbus_pkg::paddr_bits-1:0] paddr,
    input  logic [31:0]                     pwdata,
    input  logic [3:0]                      pstrb,
    output logic [31:0]                     prdata,
    output logic                            pready,
    output logic                            pslverr,
    input  logic                            clk,
    input  logic                            nreset,
    output logic                            hb_ck,
    output logic                            hb_ncs,
    output logic                            hb_nreset,
    output logic                            hb_rwds_out,
    output logic                            hb_rwds_oe,
    output logic [7:0]                      hb_dq_out,
    output logic                            hb_dq_oe,
    input  logic                            hb_rwds_in,
    input  logic [7:0]                      hb_dq_in
);
    import hbus_pkg::*;

    hb_req_t     req;
    hb_pads_t    pads;
    logic        req_valid;
    logic        done;
    logic [2:0]  ca_index;
    logic [1:0]  byte_index;
    logic        byte_take;
    logic [7:0]  ca_byte;
    logic [7:0]  wr_byte;
    logic        wr_mask;
    logic [31:0] rd_word;

    apb_port u_apb_port (
        .clk       (clk),
        .nreset    (nreset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .req_valid (req_valid),
        .req       (req),
        .done      (done),
        .rd_word   (rd_word)
    );

    hbus_sequencer u_sequencer (
        .clk        (clk),
        .nreset     (nreset),
        .req_valid  (req_valid),
        .is_read    (req.is_read),
        .done       (done),
        .ca_index   (ca_index),
        .byte_index (byte_index),
        .byte_take  (byte_take),
        .ca_byte    (ca_byte),
        .wr_byte    (wr_byte),
        .wr_mask    (wr_mask),
        .hb_rwds_in (hb_rwds_in),
        .pads       (pads)
    );

    ca_shifter u_ca_shifter (
        .req      (req),
        .ca_index (ca_index),
        .ca_byte  (ca_byte)
    );

    word_lanes u_word_lanes (
        .clk        (clk),
        .nreset     (nreset),
        .req        (req),
        .byte_index (byte_index),
        .byte_take  (byte_take),
        .hb_dq_in   (hb_dq_in),
        .wr_byte    (wr_byte),
        .wr_mask    (wr_mask),
        .rd_word    (rd_word)
    );

    assign hb_ck       = pads.ck;
    assign hb_ncs      = pads.ncs;
    assign hb_rwds_out = pads.rwds;
    assign hb_rwds_oe  = pads.rwds_oe;
    assign hb_dq_out   = pads.dq;
    assign hb_dq_oe    = pads.dq_oe;
    assign hb_nreset   = nreset;   // device reset follows the system reset

endmodule

// File: dv/clk_gen.sv
module clk_gen (
    output logic clk,
    output logic nreset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;    // 40 ns period
    end

    initial begin
        nreset = 1'b0;
        repeat (3) @(posedge clk);
        nreset <= 1'b1;
    end

endmodule

// File: dv/hyperram_model.sv
module hyperram_model (
    input  logic                          ck,
    input  logic                          ncs,
    input  logic                          nreset,
    input  logic                          rwds_in,
    input  logic                          rwds_oe,
    input  logic [7:0]                    dq_in,
    input  logic                          dq_oe,
    output logic                          rwds_out,
    output logic [7:0]                    dq_out,
    output logic                          drive,      // device owns dq and RWDS
    output logic                          ca_done,
    output logic                          ca_read,
    output logic [hbus_pkg::mem_bits-1:0] ca_addr,
    output logic                          ca_bad
);
    timeunit 1ns;
    timeprecision 1ps;
    import hbus_pkg::*;

    // data starts one bus clock short of the doubled latency, counted after the CA word
    localparam int data_edge = 6 + 2 * latency * (latency2x + 1) - 2;

    logic [31:0] mem [int];
    logic [47:0] ca;
    logic [31:0] half;
    logic [31:0] word;
    logic        last_ck;
    int          edge_cnt;
    int          n;

    initial begin
        rwds_out = 1'b0;
        dq_out   = 8'h00;
        drive    = 1'b0;
        ca_done  = 1'b0;
        ca_read  = 1'b0;
        ca_addr  = '0;
        ca_bad   = 1'b0;
        last_ck  = 1'b0;
        edge_cnt = 0;
    end

    always @(ck or ncs or nreset) begin
        if (ncs || !nreset) begin
            edge_cnt = 0;
            drive    = 1'b0;
            rwds_out = 1'b0;
            ca_done  = 1'b0;
        end else if (ck != last_ck) begin
            if (edge_cnt < 6) begin
                ca = {ca[39:0], dq_in};
                if (!dq_oe) begin
                    $display("model: dq was not driven during the command at %0t", $time);
                    ca_bad = 1'b1;
                end
                if (edge_cnt == 5) begin
                    half    = {ca[44:16], ca[2:0]};
                    ca_read = ca[47];
                    ca_addr = half[mem_bits:1];
                    ca_done = 1'b1;
                    if (ca[46] || !ca[45] || ca[15:3] != '0 || ca[0]) begin
                        $display("model: command word %h is not a linear memory access", ca);
                        ca_bad = 1'b1;
                    end
                    if (half[31:mem_bits+1] != '0) begin
                        $display("model: address %h lies beyond the device", half);
                        ca_bad = 1'b1;
                    end
                    // unwritten words read back a pattern made from their address
                    word = mem.exists(int'(ca_addr)) ? mem[int'(ca_addr)] : {11'h5a3, ca_addr};
                end
            end else if (edge_cnt >= data_edge && edge_cnt < data_edge + 4) begin
                n = edge_cnt - data_edge;
                if (ca_read) begin
                    drive    = 1'b1;
                    dq_out   = word[8*n +: 8];
                    rwds_out = n % 2 == 0;  // strobe toggles with each byte
                end else begin
                    if (!dq_oe || !rwds_oe) begin
                        $display("model: write byte %0d was not driven at %0t", n, $time);
                        ca_bad = 1'b1;
                    end
                    if (!rwds_in) begin
                        word[8*n +: 8] = dq_in;
                    end
                    if (n == 3) begin
                        mem[int'(ca_addr)] = word;
                    end
                end
            end
            edge_cnt = edge_cnt + 1;
        end
        last_ck = ck;
    end

endmodule

// File: dv/tb_hyperram_bridge.sv
module tb_hyperram_bridge;
    timeunit 1ns;
    timeprecision 1ps;
    import hbus_pkg::*;

    localparam logic [mem_bits-1:0] base_word = 21'h15_a3c0;
    localparam int window = 8;
    localparam int transfers = window + 6 + 50;
    localparam int write_cycles = 9 + nop_cycles + 4;
    localparam int cycle_limit = transfers * (nop_cycles + 20) * 3 / 2;

    logic                  clk;
    logic                  nreset;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [paddr_bits-1:0] paddr;
    logic [31:0]           pwdata;
    logic [3:0]            pstrb;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  hb_ck;
    logic                  hb_ncs;
    logic                  hb_nreset;
    logic                  hb_rwds_out;
    logic                  hb_rwds_oe;
    logic [7:0]            hb_dq_out;
    logic                  hb_dq_oe;
    logic                  hb_rwds_in;
    logic [7:0]            hb_dq_in;
    logic                  dev_drive;
    logic                  ca_done;
    logic                  ca_read;
    logic [mem_bits-1:0]   ca_addr;
    logic                  ca_bad;

    // what the transfer in progress should produce
    logic                  exp_read;
    logic                  exp_odd;
    logic [mem_bits-1:0]   exp_addr;
    logic [31:0]           exp_data;
    logic [31:0]           shadow [window];
    int                    xfer_cycles = 0;
    int                    cycle_cnt = 0;
    integer                seed;
    logic [31:0]           rnd;

    clk_gen u_clk_gen (.clk(clk), .nreset(nreset));

    hyperram_bridge UUT (
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .clk(clk), .nreset(nreset), .hb_ck(hb_ck),
        .hb_ncs(hb_ncs), .hb_nreset(hb_nreset), .hb_rwds_out(hb_rwds_out),
        .hb_rwds_oe(hb_rwds_oe), .hb_dq_out(hb_dq_out), .hb_dq_oe(hb_dq_oe),
        .hb_rwds_in(hb_rwds_in), .hb_dq_in(hb_dq_in)
    );

    hyperram_model u_model (
        .ck(hb_ck), .ncs(hb_ncs), .nreset(hb_nreset), .rwds_in(hb_rwds_out),
        .rwds_oe(hb_rwds_oe), .dq_in(hb_dq_out), .dq_oe(hb_dq_oe),
        .rwds_out(hb_rwds_in), .dq_out(hb_dq_in), .drive(dev_drive),
        .ca_done(ca_done), .ca_read(ca_read), .ca_addr(ca_addr), .ca_bad(ca_bad)
    );

    task automatic stop_with_failure;
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic apb_transfer(input logic write, input int idx, input logic [1:0] offset,
                                input logic [31:0] data, input logic [3:0] strb);
        logic [mem_bits-1:0] word;
        word = base_word + mem_bits'(idx);
        @(posedge clk);
        psel     <= 1'b1;
        penable  <= 1'b0;
        pwrite   <= write;
        paddr    <= {word, offset};
        pwdata   <= data;
        pstrb    <= strb;
        exp_read <= !write;
        exp_odd  <= offset != 2'b00;
        exp_addr <= word;
        exp_data <= shadow[idx];
        @(posedge clk);
        penable <= 1'b1;
        do @(posedge clk); while (!pready);
        psel    <= 1'b0;
        penable <= 1'b0;
        for (int b = 0; b < 4; b++) begin
            if (write && offset == 2'b00 && strb[b]) begin
                shadow[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    // cycles since setup, and the overall run limit
    always @(posedge clk) begin
        xfer_cycles <= psel ? xfer_cycles + 1 : 0;
        cycle_cnt   <= cycle_cnt + 1;
        if (cycle_cnt == cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            stop_with_failure();
        end
    end

    assert property (@(posedge clk) hb_nreset == nreset)
    else begin
        $display("Error at %0t: hb_nreset = %b, expected %b", $time,
                 $sampled(hb_nreset), $sampled(nreset));
        stop_with_failure();
    end

    assert property (@(posedge clk) disable iff (!nreset) hb_ncs |-> !hb_dq_oe && !hb_rwds_oe)
    else begin
        $display("the bridge drove the bus while chip select was high at %0t", $time);
        stop_with_failure();
    end

    assert property (@(posedge clk) disable iff (!nreset) !psel || exp_odd |-> hb_ncs)
    else begin
        $display("chip select fell with no aligned transfer pending at %0t", $time);
        stop_with_failure();
    end

    assert property (@(posedge clk) disable iff (!nreset) dev_drive |-> !hb_dq_oe && !hb_rwds_oe)
    else begin
        $display("the bridge drove the bus during read data at %0t", $time);
        stop_with_failure();
    end

    assert property (@(posedge clk) disable iff (!nreset) pready |-> pslverr == exp_odd)
    else begin
        $display("Error at %0t: pslverr = %b, expected %b", $time,
                 $sampled(pslverr), $sampled(exp_odd));
        stop_with_failure();
    end

    assert property (@(posedge clk) disable iff (!nreset)
        pready && exp_odd |-> xfer_cycles == 2)
    else begin
        $display("Error at %0t: misaligned cycles = %0d, expected 2", $time,
                 $sampled(xfer_cycles));
        stop_with_failure();
    end

    assert property (@(posedge clk) disable iff (!nreset)
        pready && !exp_odd && !exp_read |-> xfer_cycles == write_cycles)
    else begin
        $display("Error at %0t: write cycles = %0d, expected %0d", $time,
                 $sampled(xfer_cycles), write_cycles);
        stop_with_failure();
    end

    assert property (@(posedge clk) disable iff (!nreset)
        pready && !exp_odd && exp_read |-> prdata == exp_data)
    else begin
        $display("Error at %0t: prdata = %h, expected %h", $time,
                 $sampled(prdata), $sampled(exp_data));
        stop_with_failure();
    end

    assert property (@(posedge clk) disable iff (!nreset) ca_done |-> ca_read == exp_read)
    else begin
        $display("Error at %0t: ca_read = %b, expected %b", $time,
                 $sampled(ca_read), $sampled(exp_read));
        stop_with_failure();
    end

    assert property (@(posedge clk) disable iff (!nreset) ca_done |-> ca_addr == exp_addr)
    else begin
        $display("Error at %0t: ca_addr = %h, expected %h", $time,
                 $sampled(ca_addr), $sampled(exp_addr));
        stop_with_failure();
    end

    assert property (@(posedge clk) disable iff (!nreset) !ca_bad)
    else begin
        $display("the device model rejected a bus transaction at %0t", $time);
        stop_with_failure();
    end

    initial begin
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        pstrb    = '0;
        exp_read = 1'b0;
        exp_odd  = 1'b0;
        exp_addr = '0;
        exp_data = '0;
        seed     = 32'h91e4_ed0f;
        @(posedge nreset);
        for (int i = 0; i < window; i++) begin
            apb_transfer(1'b1, i, 2'b00, $random(seed), 4'hf);
        end
        apb_transfer(1'b1, 3, 2'b00, 32'hdead_beef, 4'hf);
        apb_transfer(1'b0, 3, 2'b00, 32'h0, 4'h0);
        apb_transfer(1'b1, 3, 2'b00, 32'h1122_3344, 4'b0101);  // only bytes 0 and 2 change
        apb_transfer(1'b0, 3, 2'b00, 32'h0, 4'h0);
        apb_transfer(1'b0, 5, 2'b10, 32'h0, 4'h0);
        apb_transfer(1'b1, 6, 2'b01, 32'hffff_ffff, 4'hf);
        for (int k = 0; k < 50; k++) begin
            rnd = $random(seed);
            apb_transfer(rnd[4], int'(rnd[2:0]), 2'b00, $random(seed), rnd[11:8]);
        end
        repeat (2) @(posedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule

// File: hyperram_bridge.f
src/hbus_pkg.sv
src/apb_port.sv
src/hbus_sequencer.sv
src/ca_shifter.sv
src/word_lanes.sv
src/hyperram_bridge.sv
dv/clk_gen.sv
dv/hyperram_model.sv
dv/tb_hyperram_bridge.sv

// File: Makefile
TOP = tb_hyperram_bridge

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f hyperram_bridge.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^all tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
